// ==== list.f ====
+incdir+.
pipeline_types.sv
regfile.sv
decode.sv
dispatch.sv
ex.sv
mem.sv
ctrl.sv
backend.sv
tb_backend.sv

// ==== Bender.yml ====
package:
  name: backend

sources:
  - include_dirs:
      - .
    files:
      - pipeline_types.sv
      - regfile.sv
      - decode.sv
      - dispatch.sv
      - ex.sv
      - mem.sv
      - ctrl.sv
      - backend.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_backend.sv

// ==== tb_backend.sv ====
`timescale 1ns/10ps
`include "backend_settings.svh"

module tb_backend
    import pipeline_types::*;
();

    localparam int MAX_PROG     = 32;
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_CYCLES = 10;
    localparam int RND_LEN      = 24;

    logic        clk = 1'b0;
    logic        reset_i;
    pc_id_t      id_i;
    logic        pause_o;
    logic        branch_flush_o;
    word_t       branch_target_o;
    data_write_t commit_o;

    // program and expected results for the current phase
    word_t     prog [MAX_PROG];
    int        prog_len;
    reg_addr_t exp_rd [MAX_PROG];
    word_t     exp_val [MAX_PROG];
    int        exp_len;
    word_t     exp_target [4];
    int        exp_flushes;
    int        exp_pauses;

    word_t       fetch_pc;
    logic [31:0] rng_state;
    logic        running = 1'b0;
    int          commit_idx;
    int          pause_cycles;
    int          flush_count;
    int          cycle_count;
    int          cycle_limit;
    int          checks = 0;
    int          errors = 0;
    string       phase_name;

    backend backend_inst (
        .clk,
        .reset_i,
        .id_i,
        .pause_o,
        .branch_flush_o,
        .branch_target_o,
        .commit_o
    );

    always #4 clk = ~clk;

    function automatic word_t encode(op_t op, reg_addr_t rd, reg_addr_t rs1,
                                     reg_addr_t rs2, imm_t imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic expect_commit(input reg_addr_t rd, input word_t val);
        exp_rd[exp_len]  = rd;
        exp_val[exp_len] = val;
        exp_len++;
    endtask

    task automatic load_directed_program();
        prog[0]  = encode(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'd5);
        prog[1]  = encode(OP_ADDI, 4'd2, 4'd1, 4'd0, 16'd3);
        prog[2]  = encode(OP_ADD, 4'd3, 4'd1, 4'd2, 16'd0);
        prog[3]  = encode(OP_SUB, 4'd4, 4'd3, 4'd1, 16'd0);
        prog[4]  = encode(OP_XOR, 4'd5, 4'd4, 4'd2, 16'd0);
        prog[5]  = encode(OP_OR, 4'd6, 4'd3, 4'd4, 16'd0);
        prog[6]  = encode(OP_AND, 4'd7, 4'd3, 4'd6, 16'd0);
        prog[7]  = encode(OP_SLT, 4'd8, 4'd4, 4'd3, 16'd0);
        prog[8]  = encode(OP_ADDI, 4'd9, 4'd0, 4'd0, 16'hffff);
        prog[9]  = encode(OP_SLT, 4'd10, 4'd9, 4'd1, 16'd0);
        // store r3 at r2 + 4, then load it back
        prog[10] = encode(OP_ST, 4'd0, 4'd2, 4'd3, 16'd4);
        prog[11] = encode(OP_LD, 4'd11, 4'd2, 4'd0, 16'd4);
        prog[12] = encode(OP_ADD, 4'd12, 4'd11, 4'd1, 16'd0);
        prog[13] = encode(OP_ADDI, 4'd13, 4'd0, 4'd0, 16'd1000);
        prog[14] = encode(OP_ADDI, 4'd14, 4'd0, 4'd0, 16'hfff9);
        prog[15] = encode(OP_MUL, 4'd15, 4'd13, 4'd14, 16'd0);
        prog[16] = encode(OP_ADD, 4'd1, 4'd15, 4'd13, 16'd0);
        // taken, skips 18
        prog[17] = encode(OP_BEQ, 4'd0, 4'd5, 4'd0, 16'd2);
        prog[18] = encode(OP_ADDI, 4'd2, 4'd0, 4'd0, 16'd77);
        // not taken
        prog[19] = encode(OP_BNE, 4'd0, 4'd8, 4'd10, 16'd5);
        prog[20] = encode(OP_ADDI, 4'd0, 4'd0, 4'd0, 16'd9);
        prog[21] = encode(OP_ADD, 4'd2, 4'd0, 4'd1, 16'd0);
        // taken on a forwarded operand, skips 23
        prog[22] = encode(OP_BNE, 4'd0, 4'd2, 4'd0, 16'd2);
        prog[23] = encode(OP_ADDI, 4'd3, 4'd0, 4'd0, 16'd55);
        prog[24] = encode(OP_XOR, 4'd4, 4'd0, 4'd12, 16'd0);
        prog_len = 25;

        exp_len = 0;
        expect_commit(4'd1, 32'd5);
        expect_commit(4'd2, 32'd8);
        expect_commit(4'd3, 32'd13);
        expect_commit(4'd4, 32'd8);
        expect_commit(4'd5, 32'd0);
        expect_commit(4'd6, 32'd13);
        expect_commit(4'd7, 32'd13);
        expect_commit(4'd8, 32'd1);
        expect_commit(4'd9, 32'hffff_ffff);
        expect_commit(4'd10, 32'd1);
        expect_commit(4'd11, 32'd13);
        expect_commit(4'd12, 32'd18);
        expect_commit(4'd13, 32'd1000);
        expect_commit(4'd14, -32'sd7);
        expect_commit(4'd15, -32'sd7000);
        expect_commit(4'd1, -32'sd6000);
        expect_commit(4'd0, 32'd9);
        expect_commit(4'd2, -32'sd6000);
        expect_commit(4'd4, 32'd18);

        exp_target[0] = 32'd17 * 4 + 32'd2 * 4;
        exp_target[1] = 32'd22 * 4 + 32'd2 * 4;
        exp_flushes   = 2;
        exp_pauses    = 1 + `BACKEND_MUL_STEPS;
    endtask

    task automatic build_random_program();
        word_t       model [16];
        logic [31:0] r;
        logic [31:0] r2;
        op_t         op;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        imm_t        imm;
        word_t       a;
        word_t       b;
        word_t       v;

        for (int k = 0; k < 16; k++) begin
            model[k] = '0;
        end
        exp_len = 0;
        for (int i = 0; i < RND_LEN; i++) begin
            r   = lcg_next();
            r2  = lcg_next();
            // low registers only, so neighbours depend on each other often
            rd  = {1'b0, r[26:24]};
            rs1 = {1'b0, r[22:20]};
            rs2 = {1'b0, r[18:16]};
            imm = r2[31:16];
            case (r[31:28] % 7)
                0: op = OP_ADD;
                1: op = OP_SUB;
                2: op = OP_AND;
                3: op = OP_OR;
                4: op = OP_XOR;
                5: op = OP_SLT;
                default: op = OP_ADDI;
            endcase
            a = model[rs1];
            b = (op == OP_ADDI) ? {{16{imm[15]}}, imm} : model[rs2];
            case (op)
                OP_ADD, OP_ADDI: v = a + b;
                OP_SUB: v = a - b;
                OP_AND: v = a & b;
                OP_OR:  v = a | b;
                OP_XOR: v = a ^ b;
                default: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            endcase
            prog[i] = encode(op, rd, rs1, rs2, imm);
            expect_commit(rd, v);
            if (rd != '0) begin
                model[rd] = v;
            end
        end
        prog_len    = RND_LEN;
        exp_flushes = 0;
        exp_pauses  = 0;
    endtask

    // reset is already high when this starts
    task automatic run_phase(input string name);
        phase_name   = name;
        cycle_limit  = 12 * prog_len;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i      <= 1'b0;
        pause_cycles = 0;
        flush_count  = 0;
        cycle_count  = 0;
        running      = 1'b1;

        for (commit_idx = 0; commit_idx < exp_len; commit_idx++) begin
            do begin
                @(negedge clk);
            end while (!commit_o.write_en);
            checks++;
            assert (commit_o.write_addr == exp_rd[commit_idx] &&
                    commit_o.write_data == exp_val[commit_idx]) else begin
                errors++;
                $display("Fail at %0t: %s commit %0d expected r%0d = %h, got r%0d = %h",
                         $time, name, commit_idx, exp_rd[commit_idx], exp_val[commit_idx],
                         commit_o.write_addr, commit_o.write_data);
            end
        end

        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            assert (!commit_o.write_en) else begin
                errors++;
                $display("Extra commit at %0t in %s phase: r%0d = %h was not expected",
                         $time, name, commit_o.write_addr, commit_o.write_data);
            end
        end
        running = 1'b0;

        checks += 2;
        assert (pause_cycles == exp_pauses) else begin
            errors++;
            $display("Fail at %0t: %s phase saw pause_o high for %0d cycles, expected %0d",
                     $time, name, pause_cycles, exp_pauses);
        end
        assert (flush_count == exp_flushes) else begin
            errors++;
            $display("Fail at %0t: %s phase saw %0d branch flushes, expected %0d",
                     $time, name, flush_count, exp_flushes);
        end
    endtask

    // front end, holds the word while paused and follows a flush to its target
    always @(posedge clk) begin : front_end
        int slot;
        if (reset_i) begin
            fetch_pc = '0;
            id_i     <= '0;
        end else begin
            if (branch_flush_o) begin
                fetch_pc = branch_target_o;
            end else if (id_i.valid && !pause_o) begin
                fetch_pc = fetch_pc + 32'd4;
            end
            slot = int'(fetch_pc >> 2);
            id_i.valid <= slot < prog_len;
            id_i.pc    <= fetch_pc;
            id_i.instr <= (slot < prog_len) ? prog[slot] : '0;
        end
    end

    always @(negedge clk) begin
        if (running && !reset_i) begin
            if (pause_o) begin
                pause_cycles++;
            end
            if (branch_flush_o) begin
                if (flush_count < exp_flushes) begin
                    checks++;
                    assert (branch_target_o == exp_target[flush_count]) else begin
                        errors++;
                        $display("Fail at %0t: branch target %h, expected %h",
                                 $time, branch_target_o, exp_target[flush_count]);
                    end
                end else begin
                    errors++;
                    $display("Unexpected branch flush at %0t toward %h",
                             $time, branch_target_o);
                end
                flush_count++;
            end
        end
    end

    always @(posedge clk) begin
        if (running) begin
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("Timeout in %s phase after %0d cycles, commit %0d of %0d never arrived",
                         phase_name, cycle_count, commit_idx, exp_len);
                $display("Commits checked: %0d, errors: %0d", checks, errors + 1);
                $display("Simulation finished: FAIL");
                $finish;
            end
        end
    end

    initial begin
        reset_i   = 1'b1;
        id_i      = '0;
        rng_state = 32'hdaed;

        load_directed_program();
        run_phase("directed");

        @(posedge clk);
        reset_i <= 1'b1;
        build_random_program();
        run_phase("random");

        $display("Commits checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== backend.sv ====
`timescale 1ns/10ps

module backend
    import pipeline_types::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  pc_id_t      id_i,
    output logic        pause_o,
    output logic        branch_flush_o,
    output word_t       branch_target_o,
    output data_write_t commit_o
);

    // regfile
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rdata1;
    word_t     rdata2;

    // stage registers
    id_dispatch_t id_dispatch;
    dispatch_ex_t dispatch_ex;
    ex_mem_t      ex_mem;

    // forwarding and hazards
    push_forward_t ex_push_forward;
    push_forward_t mem_push_forward;
    logic          ex_is_load;
    reg_addr_t     ex_rd;

    // ctrl
    pause_t pause_req;
    ctrl_t  ctrl;

    regfile u_regfile (
        .clk,
        .reset_i,
        .data_write_i(commit_o),
        .rs1_i(rs1),
        .rs2_i(rs2),
        .rdata1_o(rdata1),
        .rdata2_o(rdata2)
    );

    decode u_decode (
        .clk,
        .reset_i,
        .pc_id_i(id_i),
        .ctrl_i(ctrl),
        .pause_i(pause_o),
        .id_dispatch_o(id_dispatch)
    );

    dispatch u_dispatch (
        .clk,
        .reset_i,
        .id_dispatch_i(id_dispatch),
        .ctrl_i(ctrl),
        .ex_push_forward_i(ex_push_forward),
        .mem_push_forward_i(mem_push_forward),
        .ex_is_load_i(ex_is_load),
        .ex_rd_i(ex_rd),
        .rs1_o(rs1),
        .rs2_o(rs2),
        .rdata1_i(rdata1),
        .rdata2_i(rdata2),
        .pause_dispatch_o(pause_req.pause_dispatch),
        .branch_flush_o(branch_flush_o),
        .branch_target_o(branch_target_o),
        .dispatch_ex_o(dispatch_ex)
    );

    ex u_ex (
        .clk,
        .reset_i,
        .dispatch_ex_i(dispatch_ex),
        .ctrl_i(ctrl),
        .pause_ex_o(pause_req.pause_ex),
        .ex_push_forward_o(ex_push_forward),
        .ex_is_load_o(ex_is_load),
        .ex_rd_o(ex_rd),
        .ex_mem_o(ex_mem)
    );

    mem u_mem (
        .clk,
        .reset_i,
        .ex_mem_i(ex_mem),
        .ctrl_i(ctrl),
        .mem_push_forward_o(mem_push_forward),
        .data_write_o(commit_o)
    );

    ctrl u_ctrl (
        .pause_i(pause_req),
        .branch_flush_i(branch_flush_o),
        .ctrl_o(ctrl),
        .pause_o(pause_o)
    );

endmodule

// ==== ctrl.sv ====
`timescale 1ns/10ps

module ctrl
    import pipeline_types::*;
(
    input  pause_t pause_i,
    input  logic   branch_flush_i,
    output ctrl_t  ctrl_o,
    output logic   pause_o
);

    assign pause_o = pause_i.pause_dispatch || pause_i.pause_ex;

    always_comb begin
        // everything at or before the paused stage holds
        ctrl_o.stall_decode   = pause_o;
        ctrl_o.stall_dispatch = pause_o;
        ctrl_o.stall_ex       = pause_i.pause_ex;

        // the stage after the paused one gets a bubble
        ctrl_o.bubble_ex  = pause_i.pause_dispatch && !pause_i.pause_ex;
        ctrl_o.bubble_mem = pause_i.pause_ex;

        ctrl_o.flush_decode = branch_flush_i;
    end

endmodule

// ==== mem.sv ====
`timescale 1ns/10ps
`include "backend_settings.svh"

module mem
    import pipeline_types::*;
(
    input  logic          clk,
    input  logic          reset_i,
    input  ex_mem_t       ex_mem_i,
    input  ctrl_t         ctrl_i,
    output push_forward_t mem_push_forward_o,
    output data_write_t   data_write_o
);

    localparam int AW = $clog2(`BACKEND_DMEM_WORDS);

    word_t         dmem [`BACKEND_DMEM_WORDS];
    logic          bubble_q;
    logic          live;
    logic [AW-1:0] word_idx;
    word_t         wb_data;

    // entry captured while ex was paused is a bubble
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bubble_q <= 1'b0;
        end else begin
            bubble_q <= ctrl_i.bubble_mem;
        end
    end

    assign live     = ex_mem_i.valid && !bubble_q;
    assign word_idx = ex_mem_i.result[AW+1:2];

    always_ff @(posedge clk) begin
        if (live && ex_mem_i.is_store) begin
            dmem[word_idx] <= ex_mem_i.store_data;
        end
    end

    assign wb_data = ex_mem_i.is_load ? dmem[word_idx] : ex_mem_i.result;

    assign mem_push_forward_o.reg_write_en   = live && ex_mem_i.reg_write;
    assign mem_push_forward_o.reg_write_addr = ex_mem_i.rd;
    assign mem_push_forward_o.reg_write_data = wb_data;

    always_ff @(posedge clk) begin
        data_write_o.write_addr <= ex_mem_i.rd;
        data_write_o.write_data <= wb_data;
        if (reset_i) begin
            data_write_o.write_en <= 1'b0;
        end else begin
            data_write_o.write_en <= live && ex_mem_i.reg_write;
        end
    end

endmodule

// ==== ex.sv ====
`timescale 1ns/10ps
`include "backend_settings.svh"

module ex
    import pipeline_types::*;
(
    input  logic          clk,
    input  logic          reset_i,
    input  dispatch_ex_t  dispatch_ex_i,
    input  ctrl_t         ctrl_i,
    output logic          pause_ex_o,
    output push_forward_t ex_push_forward_o,
    output logic          ex_is_load_o,
    output reg_addr_t     ex_rd_o,
    output ex_mem_t       ex_mem_o
);

    localparam int STEP_BITS = 32 / `BACKEND_MUL_STEPS;
    localparam int CNT_W = $clog2(`BACKEND_MUL_STEPS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`BACKEND_MUL_STEPS - 1);

    mul_state_e       mul_state;
    logic [CNT_W-1:0] mul_cnt;
    word_t            mul_acc;
    word_t            mul_mcand;
    word_t            mul_mplier;
    word_t            step_mcand;
    word_t            step_mplier;
    word_t            partial;
    logic             is_mul;
    word_t            result;
    ex_mem_t          next;

    assign is_mul = dispatch_ex_i.valid && dispatch_ex_i.op == OP_MUL;
    assign pause_ex_o = is_mul && mul_state != MUL_DONE;

    // first step is taken straight from the operands
    assign step_mcand  = (mul_state == MUL_IDLE) ? dispatch_ex_i.operand_a : mul_mcand;
    assign step_mplier = (mul_state == MUL_IDLE) ? dispatch_ex_i.operand_b : mul_mplier;
    assign partial     = step_mcand * word_t'(step_mplier[STEP_BITS-1:0]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mul_state <= MUL_IDLE;
            mul_cnt   <= '0;
        end else begin
            case (mul_state)
                MUL_IDLE: begin
                    if (is_mul) begin
                        mul_state <= MUL_RUN;
                        mul_cnt   <= CNT_W'(1);
                    end
                end
                MUL_RUN: begin
                    mul_cnt <= mul_cnt + 1'b1;
                    if (mul_cnt == CNT_LAST) begin
                        mul_state <= MUL_DONE;
                    end
                end
                default: begin
                    mul_state <= MUL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mul_state != MUL_DONE) begin
            mul_acc    <= (mul_state == MUL_IDLE) ? partial : mul_acc + partial;
            mul_mcand  <= step_mcand << STEP_BITS;
            mul_mplier <= step_mplier >> STEP_BITS;
        end
    end

    always_comb begin
        case (dispatch_ex_i.op)
            OP_ADD, OP_ADDI, OP_LD, OP_ST: result = dispatch_ex_i.operand_a + dispatch_ex_i.operand_b;
            OP_SUB: result = dispatch_ex_i.operand_a - dispatch_ex_i.operand_b;
            OP_AND: result = dispatch_ex_i.operand_a & dispatch_ex_i.operand_b;
            OP_OR:  result = dispatch_ex_i.operand_a | dispatch_ex_i.operand_b;
            OP_XOR: result = dispatch_ex_i.operand_a ^ dispatch_ex_i.operand_b;
            OP_SLT: begin
                result = {31'b0, $signed(dispatch_ex_i.operand_a) < $signed(dispatch_ex_i.operand_b)};
            end
            OP_MUL: result = mul_acc;
            default: result = '0;
        endcase
    end

    assign ex_is_load_o = dispatch_ex_i.valid && dispatch_ex_i.op == OP_LD;
    assign ex_rd_o      = dispatch_ex_i.rd;

    // no forward for loads or while the multiplier holds ex
    assign ex_push_forward_o.reg_write_en   = dispatch_ex_i.valid && dispatch_ex_i.reg_write &&
                                              !ex_is_load_o && !ctrl_i.stall_ex;
    assign ex_push_forward_o.reg_write_addr = dispatch_ex_i.rd;
    assign ex_push_forward_o.reg_write_data = result;

    always_comb begin
        next.valid      = dispatch_ex_i.valid;
        next.rd         = dispatch_ex_i.rd;
        next.result     = result;
        next.store_data = dispatch_ex_i.store_data;
        next.reg_write  = dispatch_ex_i.reg_write;
        next.is_load    = ex_is_load_o;
        next.is_store   = dispatch_ex_i.op == OP_ST;
    end

    always_ff @(posedge clk) begin
        ex_mem_o <= next;
        if (reset_i) begin
            ex_mem_o.valid <= 1'b0;
        end
    end

endmodule

// ==== dispatch.sv ====
`timescale 1ns/10ps

module dispatch
    import pipeline_types::*;
(
    input  logic          clk,
    input  logic          reset_i,
    input  id_dispatch_t  id_dispatch_i,
    input  ctrl_t         ctrl_i,
    input  push_forward_t ex_push_forward_i,
    input  push_forward_t mem_push_forward_i,
    input  logic          ex_is_load_i,
    input  reg_addr_t     ex_rd_i,
    output reg_addr_t     rs1_o,
    output reg_addr_t     rs2_o,
    input  word_t         rdata1_i,
    input  word_t         rdata2_i,
    output logic          pause_dispatch_o,
    output logic          branch_flush_o,
    output word_t         branch_target_o,
    output dispatch_ex_t  dispatch_ex_o
);

    word_t        src1;
    word_t        src2;
    word_t        imm_ext;
    logic         uses_rs1;
    logic         use_imm;
    logic         taken;
    dispatch_ex_t next;

    // ex result is youngest, then mem, then regfile
    function automatic word_t pick_operand(reg_addr_t rs, word_t reg_val,
                                           push_forward_t ex_fw, push_forward_t mem_fw);
        if (rs != '0 && ex_fw.reg_write_en && ex_fw.reg_write_addr == rs) begin
            return ex_fw.reg_write_data;
        end
        if (rs != '0 && mem_fw.reg_write_en && mem_fw.reg_write_addr == rs) begin
            return mem_fw.reg_write_data;
        end
        return reg_val;
    endfunction

    assign rs1_o = id_dispatch_i.rs1;
    assign rs2_o = id_dispatch_i.rs2;

    assign src1 = pick_operand(rs1_o, rdata1_i, ex_push_forward_i, mem_push_forward_i);
    assign src2 = pick_operand(rs2_o, rdata2_i, ex_push_forward_i, mem_push_forward_i);

    assign imm_ext  = {{16{id_dispatch_i.imm[15]}}, id_dispatch_i.imm};
    assign uses_rs1 = id_dispatch_i.op != OP_NOP;
    assign use_imm  = id_dispatch_i.op inside {OP_ADDI, OP_LD, OP_ST};

    // load result only exists once it reaches mem
    assign pause_dispatch_o = id_dispatch_i.valid && ex_is_load_i && ex_rd_i != '0 &&
                              ((uses_rs1 && rs1_o == ex_rd_i) ||
                               (id_dispatch_i.uses_rs2 && rs2_o == ex_rd_i));

    assign taken = id_dispatch_i.valid &&
                   ((id_dispatch_i.op == OP_BEQ && src1 == src2) ||
                    (id_dispatch_i.op == OP_BNE && src1 != src2));

    assign branch_flush_o  = taken && !ctrl_i.stall_dispatch;
    assign branch_target_o = id_dispatch_i.pc + (imm_ext << 2);

    always_comb begin
        next.valid      = id_dispatch_i.valid;
        next.op         = id_dispatch_i.op;
        next.rd         = id_dispatch_i.rd;
        next.operand_a  = src1;
        next.operand_b  = use_imm ? imm_ext : src2;
        next.store_data = src2;
        next.reg_write  = id_dispatch_i.reg_write;
    end

    always_ff @(posedge clk) begin
        if (!ctrl_i.stall_ex) begin
            dispatch_ex_o <= next;
            if (ctrl_i.bubble_ex) begin
                dispatch_ex_o.valid <= 1'b0;
            end
        end
        if (reset_i) begin
            dispatch_ex_o.valid <= 1'b0;
        end
    end

endmodule

// ==== decode.sv ====
`timescale 1ns/10ps

module decode
    import pipeline_types::*;
(
    input  logic         clk,
    input  logic         reset_i,
    input  pc_id_t       pc_id_i,
    input  ctrl_t        ctrl_i,
    input  logic         pause_i,
    output id_dispatch_t id_dispatch_o
);

    op_t          op;
    logic         accept;
    id_dispatch_t decoded;

    assign op = pc_id_i.instr[31:28];

    // offered word is dropped on a branch flush
    assign accept = pc_id_i.valid && !pause_i && !ctrl_i.flush_decode;

    always_comb begin
        decoded.valid     = accept;
        decoded.pc        = pc_id_i.pc;
        decoded.op        = op;
        decoded.rd        = pc_id_i.instr[27:24];
        decoded.rs1       = pc_id_i.instr[23:20];
        decoded.rs2       = pc_id_i.instr[19:16];
        decoded.imm       = pc_id_i.instr[15:0];
        decoded.reg_write = 1'b0;
        decoded.uses_rs2  = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_MUL: begin
                decoded.reg_write = 1'b1;
                decoded.uses_rs2  = 1'b1;
            end
            OP_ADDI, OP_LD: begin
                decoded.reg_write = 1'b1;
            end
            OP_ST, OP_BEQ, OP_BNE: begin
                decoded.uses_rs2 = 1'b1;
            end
            // nop and unused encodings do nothing
            default: begin
                decoded.reg_write = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!ctrl_i.stall_decode) begin
            id_dispatch_o <= decoded;
        end
        if (reset_i) begin
            id_dispatch_o.valid <= 1'b0;
        end
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/10ps
`include "backend_settings.svh"

module regfile
    import pipeline_types::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  data_write_t data_write_i,
    input  reg_addr_t   rs1_i,
    input  reg_addr_t   rs2_i,
    output word_t       rdata1_o,
    output word_t       rdata2_o
);

    word_t regs [`BACKEND_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `BACKEND_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (data_write_i.write_en && data_write_i.write_addr != '0) begin
            regs[data_write_i.write_addr] <= data_write_i.write_data;
        end
    end

    // write-through so wb needs no separate forward path
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (data_write_i.write_en && data_write_i.write_addr == addr) begin
            return data_write_i.write_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = read_port(rs1_i);
        rdata2_o = read_port(rs2_i);
    end

endmodule

// ==== pipeline_types.sv ====
package pipeline_types;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [3:0]  op_t;
    typedef logic [15:0] imm_t;

    // instr layout: op[31:28] rd[27:24] rs1[23:20] rs2[19:16] imm[15:0]
    localparam op_t OP_NOP  = 4'd0;
    localparam op_t OP_ADD  = 4'd1;
    localparam op_t OP_SUB  = 4'd2;
    localparam op_t OP_AND  = 4'd3;
    localparam op_t OP_OR   = 4'd4;
    localparam op_t OP_XOR  = 4'd5;
    localparam op_t OP_SLT  = 4'd6;
    localparam op_t OP_ADDI = 4'd7;
    localparam op_t OP_MUL  = 4'd8;
    localparam op_t OP_LD   = 4'd9;
    localparam op_t OP_ST   = 4'd10;
    localparam op_t OP_BEQ  = 4'd11;
    localparam op_t OP_BNE  = 4'd12;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } pc_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        op_t       op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        imm_t      imm;
        logic      reg_write;
        logic      uses_rs2;
    } id_dispatch_t;

    typedef struct packed {
        logic      valid;
        op_t       op;
        reg_addr_t rd;
        word_t     operand_a;
        word_t     operand_b;
        word_t     store_data;
        logic      reg_write;
    } dispatch_ex_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     result;
        word_t     store_data;
        logic      reg_write;
        logic      is_load;
        logic      is_store;
    } ex_mem_t;

    typedef struct packed {
        logic      write_en;
        reg_addr_t write_addr;
        word_t     write_data;
    } data_write_t;

    typedef struct packed {
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        word_t     reg_write_data;
    } push_forward_t;

    typedef struct packed {
        logic pause_dispatch;
        logic pause_ex;
    } pause_t;

    typedef struct packed {
        logic stall_decode;
        logic stall_dispatch;
        logic stall_ex;
        logic bubble_ex;
        logic bubble_mem;
        logic flush_decode;
    } ctrl_t;

endpackage

// ==== backend_settings.svh ====
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// architectural registers, r0 reads as zero
`define BACKEND_NUM_REGS 16

// local data RAM depth in 32-bit words
`define BACKEND_DMEM_WORDS 64

// multiplier iterations, 32 / steps multiplier bits per step
`define BACKEND_MUL_STEPS 4

`endif
